// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cache_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, the simulator status is not trusted through the pipe
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^>>> PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/axil_pkg.sv
hdl/cache_ifs.sv
hdl/cache_axil_slave.sv
hdl/cache_replacement_policy.sv
hdl/cache_controller.sv
hdl/backing_store.sv
hdl/cache_top.sv
test/cache_tb.sv

// File: hdl/axil_pkg.sv
//############################################################
// AXI4-Lite field types and response codes
//############################################################
`include "cache_params.svh"

package axil_pkg;

   typedef logic [`AXIL_ADDR_W-1:0]    axil_addr_t;  // byte address
   typedef logic [`CACHE_DATA_W-1:0]   axil_data_t;
   typedef logic [`CACHE_DATA_W/8-1:0] axil_strb_t;
   typedef logic [1:0]                 axil_resp_t;

   localparam axil_resp_t OKAY   = 2'b00;
   localparam axil_resp_t SLVERR = 2'b10;

endpackage

// File: hdl/backing_store.sv
//############################################################
// backing store, 256 words with a fixed access latency
//############################################################
`timescale 1ns/1ps
`include "cache_params.svh"

module backing_store (
   input  logic clk_i,
   input  logic arst_n_i,
   mem_if.slave mem
);

   localparam int DEPTH = 1 << `CACHE_ADDR_W;
   localparam int CNT_W = $clog2(`CACHE_MEM_LAT + 1);

   cache_pkg::data_t mem_q [DEPTH];
   cache_pkg::data_t rdata_q;
   logic [CNT_W-1:0] cnt_q;  // cycles since req rose
   logic             ack_q;
   logic             done;

   // last wait cycle, access happens here and ack follows
   assign done = mem.req && !ack_q && (cnt_q == CNT_W'(`CACHE_MEM_LAT - 1));

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         mem_q <= '{default: '0};
         cnt_q <= '0;
         ack_q <= 1'b0;
      end else begin
         ack_q <= done;  // one cycle pulse
         if (done) cnt_q <= '0;
         else if (mem.req && !ack_q) cnt_q <= cnt_q + 1'b1;
         if (done && mem.we) mem_q[mem.addr] <= mem.wdata;
      end
   end

   always_ff @(posedge clk_i) begin
      if (done && !mem.we) rdata_q <= mem_q[mem.addr];
   end

   assign mem.ack   = ack_q;
   assign mem.rdata = rdata_q;

endmodule

// File: hdl/cache_axil_slave.sv
//############################################################
// AXI4-Lite slave, turns bus transfers into single cache
// requests and holds the response until the master takes it
//############################################################
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_axil_slave (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  axil_pkg::axil_addr_t awaddr_i,
   input  logic                 awvalid_i,
   output logic                 awready_o,
   input  axil_pkg::axil_data_t wdata_i,
   input  axil_pkg::axil_strb_t wstrb_i,
   input  logic                 wvalid_i,
   output logic                 wready_o,
   output axil_pkg::axil_resp_t bresp_o,
   output logic                 bvalid_o,
   input  logic                 bready_i,
   input  axil_pkg::axil_addr_t araddr_i,
   input  logic                 arvalid_i,
   output logic                 arready_o,
   output axil_pkg::axil_data_t rdata_o,
   output axil_pkg::axil_resp_t rresp_o,
   output logic                 rvalid_o,
   input  logic                 rready_i,
   cache_req_if.master          req
);

   logic                 up_q, busy_q;      // out of reset, transaction open
   logic                 aw_got_q, w_got_q; // one write channel already seen
   axil_pkg::axil_addr_t awaddr_q, wr_addr;
   axil_pkg::axil_data_t wdata_q, wr_data;
   axil_pkg::axil_strb_t wstrb_q, wr_strb;
   logic                 ar_hs, aw_hs, w_hs, wr_go, wr_bad, rd_bad, req_done;

   assign arready_o = up_q && !busy_q;
   assign awready_o = up_q && !busy_q && !aw_got_q && !arvalid_i;  // reads win a tie
   assign wready_o  = up_q && !busy_q && !w_got_q && !arvalid_i;

   assign ar_hs    = arvalid_i && arready_o;
   assign aw_hs    = awvalid_i && awready_o;
   assign w_hs     = wvalid_i && wready_o;
   assign wr_go    = (aw_got_q || aw_hs) && (w_got_q || w_hs);  // both halves present
   assign req_done = req.valid && req.ready;

   // latched half or the one arriving now
   assign wr_addr = aw_got_q ? awaddr_q : awaddr_i;
   assign wr_data = w_got_q ? wdata_q : wdata_i;
   assign wr_strb = w_got_q ? wstrb_q : wstrb_i;

   // counters are read-only, partial words unsupported
   assign wr_bad = (wr_addr >= `CACHE_HIT_CNT_ADDR) || (wr_strb != '1);
   assign rd_bad = araddr_i >= (`CACHE_MISS_CNT_ADDR + 12'd4);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         up_q      <= 1'b0;
         busy_q    <= 1'b0;
         aw_got_q  <= 1'b0;
         w_got_q   <= 1'b0;
         req.valid <= 1'b0;
         rvalid_o  <= 1'b0;
         bvalid_o  <= 1'b0;
      end else begin
         up_q     <= 1'b1;  // readies rise one cycle after reset
         aw_got_q <= !wr_go && (aw_got_q || aw_hs);
         w_got_q  <= !wr_go && (w_got_q || w_hs);
         if (ar_hs || wr_go) begin
            busy_q <= 1'b1;
         end else if ((rvalid_o && rready_i) || (bvalid_o && bready_i)) begin
            busy_q <= 1'b0;  // response taken, open for the next one
         end
         if ((ar_hs && !rd_bad) || (wr_go && !wr_bad)) begin
            req.valid <= 1'b1;
         end else if (req_done) begin
            req.valid <= 1'b0;
         end
         if ((ar_hs && rd_bad) || (req_done && !req.we)) begin
            rvalid_o <= 1'b1;
         end else if (rready_i) begin
            rvalid_o <= 1'b0;
         end
         if ((wr_go && wr_bad) || (req_done && req.we)) begin
            bvalid_o <= 1'b1;
         end else if (bready_i) begin
            bvalid_o <= 1'b0;
         end
      end
   end

   // request and response payload
   always_ff @(posedge clk_i) begin
      if (aw_hs) awaddr_q <= awaddr_i;
      if (w_hs) begin
         wdata_q <= wdata_i;
         wstrb_q <= wstrb_i;
      end
      if (ar_hs) begin
         req.we      <= 1'b0;
         req.addr    <= araddr_i[`CACHE_ADDR_W+1:2];  // byte to word
         req.cnt_sel <= (araddr_i < `CACHE_HIT_CNT_ADDR) ? 2'd0 : (araddr_i[2] ? 2'd2 : 2'd1);
      end else if (wr_go) begin
         req.we      <= 1'b1;
         req.addr    <= wr_addr[`CACHE_ADDR_W+1:2];
         req.wdata   <= wr_data;
         req.cnt_sel <= 2'd0;
      end
      if (ar_hs && rd_bad) begin
         rdata_o <= '0;
         rresp_o <= axil_pkg::SLVERR;
      end else if (req_done && !req.we) begin
         rdata_o <= req.rdata;
         rresp_o <= axil_pkg::OKAY;
      end
      if (wr_go && wr_bad) bresp_o <= axil_pkg::SLVERR;
      else if (req_done && req.we) bresp_o <= axil_pkg::OKAY;
   end

   // controller may take several cycles, the request must not move meanwhile
   a_req_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      req.valid && !req.ready |=> req.valid && $stable(req.addr) && $stable(req.we)
                                  && $stable(req.wdata) && $stable(req.cnt_sel));

endmodule

// File: hdl/cache_controller.sv
//############################################################
// cache controller, tag/valid/data arrays, miss fill,
// write-through and the read hit/miss counters
//############################################################
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_controller (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   cache_req_if.slave           req,
   mem_if.master                mem,
   output cache_pkg::set_idx_t  set_o,
   output logic                 plru_update_o,
   output cache_pkg::way_oh_t   plru_way_o,
   input  cache_pkg::way_idx_t  victim_i
);

   cache_pkg::ctrl_state_t state_q, state_d;
   cache_pkg::tag_t        tag_q   [`CACHE_N_SETS][`CACHE_N_WAYS];
   cache_pkg::data_t       data_q  [`CACHE_N_SETS][`CACHE_N_WAYS];
   cache_pkg::way_oh_t     valid_q [`CACHE_N_SETS];
   cache_pkg::data_t       hit_cnt_q, miss_cnt_q;
   cache_pkg::set_idx_t    set_idx;
   cache_pkg::tag_t        tag;
   cache_pkg::way_oh_t     hit_oh;
   cache_pkg::data_t       hit_data;
   logic                   hit, lookup, fill_done;

   assign set_idx = req.addr[`CACHE_SETS_W-1:0];  // low bits pick the set
   assign tag     = req.addr[`CACHE_ADDR_W-1:`CACHE_SETS_W];

   // parallel tag compare, or-mux of the hit way
   always_comb begin
      hit_data = '0;
      for (int w = 0; w < `CACHE_N_WAYS; w++) begin
         hit_oh[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == tag);
         if (hit_oh[w]) hit_data = hit_data | data_q[set_idx][w];
      end
   end

   assign hit       = |hit_oh;
   assign lookup    = state_q == cache_pkg::LOOKUP;
   assign fill_done = (state_q == cache_pkg::FILL_WAIT) && mem.ack;

   always_comb begin
      state_d = state_q;
      case (state_q)
         cache_pkg::IDLE:       if (req.valid && req.cnt_sel == 2'd0) state_d = cache_pkg::LOOKUP;
         cache_pkg::LOOKUP:     state_d = req.we ? cache_pkg::WRITE_REQ :
                                          hit    ? cache_pkg::IDLE : cache_pkg::FILL_REQ;
         cache_pkg::FILL_REQ:   state_d = cache_pkg::FILL_WAIT;
         cache_pkg::FILL_WAIT:  if (mem.ack) state_d = cache_pkg::RESP;
         cache_pkg::WRITE_REQ:  state_d = cache_pkg::WRITE_WAIT;
         cache_pkg::WRITE_WAIT: if (mem.ack) state_d = cache_pkg::RESP;
         default:               state_d = cache_pkg::IDLE;  // RESP
      endcase
   end

   // counters at once, read hits from lookup, fills and writes from RESP
   assign req.ready = (state_q == cache_pkg::IDLE && req.valid && req.cnt_sel != 2'd0)
                   || (lookup && !req.we && hit)
                   || (state_q == cache_pkg::RESP);
   assign req.rdata = (req.cnt_sel == 2'd1) ? hit_cnt_q  :
                      (req.cnt_sel == 2'd2) ? miss_cnt_q : hit_data;  // filled line hits in RESP

   assign mem.req   = state_q inside {cache_pkg::FILL_REQ, cache_pkg::FILL_WAIT,
                                      cache_pkg::WRITE_REQ, cache_pkg::WRITE_WAIT};
   assign mem.we    = state_q inside {cache_pkg::WRITE_REQ, cache_pkg::WRITE_WAIT};
   assign mem.addr  = req.addr;
   assign mem.wdata = req.wdata;

   // policy sees hits of both reads and writes, and every fill
   assign set_o         = set_idx;
   assign plru_update_o = (lookup && hit) || fill_done;
   assign plru_way_o    = fill_done ? cache_pkg::way_oh_t'(1) << victim_i : hit_oh;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= cache_pkg::IDLE;
         valid_q    <= '{default: '0};
         hit_cnt_q  <= '0;
         miss_cnt_q <= '0;
      end else begin
         state_q <= state_d;
         if (lookup && !req.we && hit) hit_cnt_q <= hit_cnt_q + 1'b1;
         if (fill_done) begin
            miss_cnt_q                 <= miss_cnt_q + 1'b1;  // counted once the line is in
            valid_q[set_idx][victim_i] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_done) begin
         tag_q[set_idx][victim_i]  <= tag;
         data_q[set_idx][victim_i] <= mem.rdata;
      end else if (lookup && req.we) begin
         for (int w = 0; w < `CACHE_N_WAYS; w++) begin
            if (hit_oh[w]) data_q[set_idx][w] <= req.wdata;  // write hit, keep copy current
         end
      end
   end

   // fills only follow misses, so a tag never sits in two ways of a set
   a_one_way_hits : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      lookup |-> $onehot0(hit_oh));

endmodule

// File: hdl/cache_ifs.sv
//############################################################
// internal links: bus slave to controller, controller to store
//############################################################
`timescale 1ns/1ps

// one request at a time, held until ready
interface cache_req_if;
   logic                  valid;
   logic                  we;
   cache_pkg::word_addr_t addr;
   axil_pkg::axil_data_t  wdata;
   logic [1:0]            cnt_sel;  // 0 data, 1 hit counter, 2 miss counter
   logic                  ready;    // single cycle pulse
   axil_pkg::axil_data_t  rdata;    // valid with ready

   modport master (
      output valid, we, addr, wdata, cnt_sel,
      input  ready, rdata
   );
   modport slave (
      input  valid, we, addr, wdata, cnt_sel,
      output ready, rdata
   );
endinterface

// backing store port, req held until ack
interface mem_if;
   logic                  req;
   logic                  we;
   cache_pkg::word_addr_t addr;
   cache_pkg::data_t      wdata;
   logic                  ack;    // single cycle pulse
   cache_pkg::data_t      rdata;  // valid with ack

   modport master (
      output req, we, addr, wdata,
      input  ack, rdata
   );
   modport slave (
      input  req, we, addr, wdata,
      output ack, rdata
   );
endinterface

// File: hdl/cache_params.svh
//############################################################
// cache geometry, backing store latency and bus address map
//############################################################
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

`define CACHE_N_WAYS   4    // ways per set
`define CACHE_N_SETS   4
`define CACHE_WAYS_W   2    // way index width
`define CACHE_SETS_W   2    // set index width
`define CACHE_ADDR_W   8    // word address, 256 words in the store
`define CACHE_DATA_W   32   // one word per line
`define CACHE_MEM_LAT  2    // store cycles from req to ack

// bus side, byte addressed
`define AXIL_ADDR_W          12
`define CACHE_HIT_CNT_ADDR   12'h400   // first byte above the 1 KiB data region
`define CACHE_MISS_CNT_ADDR  12'h404

`endif

// File: hdl/cache_pkg.sv
//############################################################
// cache geometry types and controller FSM states
//############################################################
`include "cache_params.svh"

package cache_pkg;

   typedef logic [`CACHE_ADDR_W-1:0]               word_addr_t;  // {tag, set}
   typedef logic [`CACHE_SETS_W-1:0]               set_idx_t;
   typedef logic [`CACHE_ADDR_W-`CACHE_SETS_W-1:0] tag_t;
   typedef logic [`CACHE_WAYS_W-1:0]               way_idx_t;
   typedef logic [`CACHE_N_WAYS-1:0]               way_oh_t;
   typedef logic [`CACHE_N_WAYS-1:1]               plru_tree_t;  // node 1 is the root
   typedef logic [`CACHE_DATA_W-1:0]               data_t;

   typedef enum logic [2:0] {
      IDLE,        // wait for a request, counters answered here
      LOOKUP,      // tag compare
      FILL_REQ,
      FILL_WAIT,   // line fetch from the store
      WRITE_REQ,
      WRITE_WAIT,  // write-through
      RESP
   } ctrl_state_t;

endpackage

// File: hdl/cache_replacement_policy.sv
//############################################################
// tree pseudo-LRU, one tree per set, victim and update
//############################################################
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_replacement_policy (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  cache_pkg::set_idx_t  set_i,
   input  logic                 update_i,
   input  cache_pkg::way_oh_t   way_hit_i,
   output cache_pkg::way_idx_t  victim_o
);

   cache_pkg::plru_tree_t tree_q [`CACHE_N_SETS];
   cache_pkg::plru_tree_t tree_d;
   cache_pkg::way_idx_t   hit_bin;

   // walk from the root, node 0 goes left and 1 goes right
   always_comb begin
      int unsigned node;
      node = 1;
      for (int lvl = 0; lvl < `CACHE_WAYS_W; lvl++) begin
         node = 2 * node + int'(tree_q[set_i][node]);  // children of n are 2n, 2n+1
      end
      victim_o = cache_pkg::way_idx_t'(node - `CACHE_N_WAYS);  // leaf id to way
   end

   always_comb begin
      hit_bin = '0;
      for (int w = 0; w < `CACHE_N_WAYS; w++) begin
         if (way_hit_i[w]) hit_bin = hit_bin | cache_pkg::way_idx_t'(w);
      end
   end

   // every node on the path points away from the accessed way
   always_comb begin
      int unsigned node;
      tree_d = tree_q[set_i];
      for (int lvl = 1; lvl <= `CACHE_WAYS_W; lvl++) begin
         node = (`CACHE_N_WAYS + hit_bin) >> (`CACHE_WAYS_W - lvl + 1);  // ancestor at lvl
         tree_d[node] = !hit_bin[`CACHE_WAYS_W - lvl];  // left half accessed, go right
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) tree_q <= '{default: '0};
      else if (update_i) tree_q[set_i] <= tree_d;
   end

   a_hit_onehot : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      update_i |-> $onehot(way_hit_i));

endmodule

// File: hdl/cache_top.sv
//############################################################
// cache top, AXI4-Lite slave in front of the controller,
// replacement policy and backing store
//############################################################
`timescale 1ns/1ps

module cache_top (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  axil_pkg::axil_addr_t awaddr_i,
   input  logic                 awvalid_i,
   output logic                 awready_o,
   input  axil_pkg::axil_data_t wdata_i,
   input  axil_pkg::axil_strb_t wstrb_i,
   input  logic                 wvalid_i,
   output logic                 wready_o,
   output axil_pkg::axil_resp_t bresp_o,
   output logic                 bvalid_o,
   input  logic                 bready_i,
   input  axil_pkg::axil_addr_t araddr_i,
   input  logic                 arvalid_i,
   output logic                 arready_o,
   output axil_pkg::axil_data_t rdata_o,
   output axil_pkg::axil_resp_t rresp_o,
   output logic                 rvalid_o,
   input  logic                 rready_i
);

   cache_req_if          req_if ();
   mem_if                mem_bus ();
   cache_pkg::set_idx_t  plru_set;
   logic                 plru_update;
   cache_pkg::way_oh_t   plru_way;
   cache_pkg::way_idx_t  victim;

   // bus ports share names with the top, so they connect by name
   cache_axil_slave u_slave (.*, .req(req_if.master));

   cache_controller u_ctrl (
      .clk_i, .arst_n_i,
      .req          (req_if.slave),
      .mem          (mem_bus.master),
      .set_o        (plru_set),
      .plru_update_o(plru_update),
      .plru_way_o   (plru_way),
      .victim_i     (victim)
   );

   cache_replacement_policy u_plru (
      .clk_i, .arst_n_i,
      .set_i    (plru_set),
      .update_i (plru_update),
      .way_hit_i(plru_way),
      .victim_o (victim)
   );

   backing_store u_store (.clk_i, .arst_n_i, .mem(mem_bus.slave));

endmodule

// File: test/cache_tb.sv
//############################################################
// cache testbench, AXI4-Lite driver tasks, reference model
// with tree pseudo-LRU and concurrent response checks
//############################################################
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_tb;

   localparam int TMO = 40;  // cycles any single wait may take

   logic                 clk_i, arst_n_i;
   axil_pkg::axil_addr_t awaddr_i, araddr_i;
   logic                 awvalid_i, awready_o, wvalid_i, wready_o;
   logic                 bvalid_o, bready_i, arvalid_i, arready_o, rvalid_o, rready_i;
   axil_pkg::axil_data_t wdata_i, rdata_o;
   axil_pkg::axil_strb_t wstrb_i;
   axil_pkg::axil_resp_t bresp_o, rresp_o;

   // reference model of store, arrays and trees
   cache_pkg::data_t      mdl_mem  [1 << `CACHE_ADDR_W];
   cache_pkg::tag_t       mdl_tag  [`CACHE_N_SETS][`CACHE_N_WAYS];
   logic                  mdl_val  [`CACHE_N_SETS][`CACHE_N_WAYS];
   cache_pkg::plru_tree_t mdl_tree [`CACHE_N_SETS];
   cache_pkg::data_t      mdl_hits, mdl_misses;

   // expectation for the one transaction in flight
   axil_pkg::axil_data_t  exp_rdata;
   axil_pkg::axil_resp_t  exp_rresp, exp_bresp;
   logic                  exp_hit;
   string                 test_name;
   integer                seed;

   cache_top dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;  // 100 ns period
   end

   task automatic abort_run();
      $display(">>> FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_mismatch(string what, logic [31:0] exp, logic [31:0] act);
      $display("ERROR %s: %s expected %h, actual %h", test_name, what, exp, act);
      abort_run();
   endtask

   task automatic report_problem(string msg);
      $display("ERROR %s: %s", test_name, msg);
      abort_run();
   endtask

   // root 0 goes left, then the pair node picks the leaf
   function automatic cache_pkg::way_idx_t tree_victim(cache_pkg::plru_tree_t t);
      if (!t[1]) return t[2] ? 2'd1 : 2'd0;
      return t[3] ? 2'd3 : 2'd2;
   endfunction

   // nodes on the path point away from the way just used
   function automatic cache_pkg::plru_tree_t tree_touch(cache_pkg::plru_tree_t t,
                                                        cache_pkg::way_idx_t w);
      cache_pkg::plru_tree_t n;
      n    = t;
      n[1] = (w < 2);                 // left half used, point right
      if (w < 2) n[2] = (w == 0);
      else       n[3] = (w == 2);
      return n;
   endfunction

   function automatic logic model_find(cache_pkg::word_addr_t a,
                                       output cache_pkg::way_idx_t w);
      logic found;
      found = 1'b0;
      w     = '0;
      for (int i = 0; i < `CACHE_N_WAYS; i++) begin
         if (mdl_val[a[1:0]][i] && mdl_tag[a[1:0]][i] == a[7:2]) begin
            found = 1'b1;
            w     = cache_pkg::way_idx_t'(i);
         end
      end
      return found;
   endfunction

   function automatic void predict_read(axil_pkg::axil_addr_t ba);
      cache_pkg::word_addr_t a;
      cache_pkg::way_idx_t   w;
      a         = ba[9:2];
      exp_hit   = 1'b0;
      exp_rresp = axil_pkg::OKAY;
      if (ba >= `CACHE_MISS_CNT_ADDR + 12'd4) begin
         exp_rresp = axil_pkg::SLVERR;  // beyond the counters
         exp_rdata = '0;
      end else if (ba >= `CACHE_HIT_CNT_ADDR) begin
         exp_rdata = ba[2] ? mdl_misses : mdl_hits;
      end else begin
         exp_hit = model_find(a, w);
         if (exp_hit) begin
            mdl_hits++;
         end else begin
            w                  = tree_victim(mdl_tree[a[1:0]]);  // fill evicts the victim
            mdl_val[a[1:0]][w] = 1'b1;
            mdl_tag[a[1:0]][w] = a[7:2];
            mdl_misses++;
         end
         mdl_tree[a[1:0]] = tree_touch(mdl_tree[a[1:0]], w);
         exp_rdata        = mdl_mem[a];
      end
   endfunction

   function automatic void predict_write(axil_pkg::axil_addr_t ba, axil_pkg::axil_data_t d,
                                         axil_pkg::axil_strb_t strb);
      cache_pkg::word_addr_t a;
      cache_pkg::way_idx_t   w;
      a = ba[9:2];
      if (strb != 4'hf || ba >= `CACHE_HIT_CNT_ADDR) begin
         exp_bresp = axil_pkg::SLVERR;  // store untouched
      end else begin
         exp_bresp  = axil_pkg::OKAY;
         mdl_mem[a] = d;  // write-through, a miss allocates nothing
         if (model_find(a, w)) mdl_tree[a[1:0]] = tree_touch(mdl_tree[a[1:0]], w);
      end
   endfunction

   // wait for rvalid or bvalid, keep the ready low for hold cycles, then take it
   task automatic take_response(logic rd, int hold);
      int n;
      n = 0;
      do begin
         @(posedge clk_i);
         n++;
         if (n > TMO) report_problem(rd ? "rvalid never came" : "bvalid never came");
      end while (!(rd ? rvalid_o : bvalid_o));
      repeat (hold) @(posedge clk_i);
      if (rd) rready_i <= 1'b1;
      else    bready_i <= 1'b1;
      @(posedge clk_i);
      rready_i <= 1'b0;
      bready_i <= 1'b0;
   endtask

   task automatic axil_read(axil_pkg::axil_addr_t ba, int hold);
      int n;
      predict_read(ba);
      @(posedge clk_i);
      araddr_i  <= ba;
      arvalid_i <= 1'b1;
      n = 0;
      do begin
         @(posedge clk_i);
         n++;
         if (n > TMO) report_problem("arready never came");
      end while (!arready_o);
      arvalid_i <= 1'b0;
      take_response(1'b1, hold);
   endtask

   task automatic axil_write(axil_pkg::axil_addr_t ba, axil_pkg::axil_data_t d,
                             axil_pkg::axil_strb_t strb, logic split, int hold);
      int   n;
      logic aw_left, w_left;
      predict_write(ba, d, strb);
      @(posedge clk_i);
      awaddr_i  <= ba;
      wdata_i   <= d;
      wstrb_i   <= strb;
      awvalid_i <= 1'b1;
      wvalid_i  <= !split;  // split sends data after the address
      aw_left = 1'b1;
      w_left  = 1'b1;
      n       = 0;
      while (aw_left || w_left) begin
         @(posedge clk_i);
         n++;
         if (n > TMO) report_problem("write address or data never accepted");
         if (awvalid_i && awready_o) begin
            aw_left = 1'b0;
            awvalid_i <= 1'b0;
            if (split) wvalid_i <= 1'b1;
         end
         if (wvalid_i && wready_o) begin
            w_left = 1'b0;
            wvalid_i <= 1'b0;
         end
      end
      take_response(1'b0, hold);
   endtask

   a_rdata : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rvalid_o && rready_i |-> rdata_o == exp_rdata)
      else report_mismatch("rdata", $sampled(exp_rdata), $sampled(rdata_o));
   a_rresp : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rvalid_o && rready_i |-> rresp_o == exp_rresp)
      else report_mismatch("rresp", $sampled(exp_rresp), $sampled(rresp_o));
   a_bresp : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      bvalid_o && bready_i |-> bresp_o == exp_bresp)
      else report_mismatch("bresp", $sampled(exp_bresp), $sampled(bresp_o));
   a_r_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
      else report_problem("read response dropped or changed before rready");
   a_b_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
      else report_problem("write response dropped or changed before bready");
   a_hit_lat : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      arvalid_i && arready_o && exp_hit |-> ##3 $rose(rvalid_o))
      else report_problem("read hit did not answer 3 cycles after the AR handshake");

   initial begin
      axil_pkg::axil_data_t d;
      seed      = 32'hbcfb_6192;
      arst_n_i  = 1'b0;
      awaddr_i  = '0;
      awvalid_i = 1'b0;
      wdata_i   = '0;
      wstrb_i   = '0;
      wvalid_i  = 1'b0;
      bready_i  = 1'b0;
      araddr_i  = '0;
      arvalid_i = 1'b0;
      rready_i  = 1'b0;
      foreach (mdl_mem[i]) mdl_mem[i] = '0;  // store clears on reset
      foreach (mdl_val[s, w]) mdl_val[s][w] = 1'b0;
      foreach (mdl_tree[s]) mdl_tree[s] = '0;
      mdl_hits   = '0;
      mdl_misses = '0;
      exp_hit    = 1'b0;
      test_name  = "reset";
      repeat (5) @(posedge clk_i);
      arst_n_i <= 1'b1;

      test_name = "write_read";
      for (int i = 0; i < 16; i++) begin
         d = $random(seed);
         axil_write(12'(i * 20), d, 4'hf, i[0], 0);  // word 5*i, four per set
      end
      for (int i = 0; i < 16; i++) begin
         axil_read(12'(i * 20), 0);  // miss, filled from the store
         axil_read(12'(i * 20), 0);  // hit
      end

      // five tags in set 1, one more than the ways
      test_name = "plru";
      for (int i = 0; i < 5; i++) axil_read(12'h204 + 12'(i * 16), 0);
      axil_read(12'h244, 0);
      axil_read(12'h204, 0);
      axil_read(12'h234, 0);
      axil_read(12'h214, 0);
      axil_read(12'h224, 0);
      axil_read(12'h244, 0);
      axil_read(`CACHE_HIT_CNT_ADDR, 0);
      axil_read(`CACHE_MISS_CNT_ADDR, 0);

      test_name = "write_update";
      d = $random(seed);
      axil_write(12'h244, d, 4'hf, 1'b0, 0);  // word 0x91 was just read
      axil_read(12'h244, 0);
      axil_read(`CACHE_HIT_CNT_ADDR, 0);
      axil_write(12'h3c0, $random(seed), 4'hf, 1'b1, 0);  // never read, stays uncached
      axil_read(`CACHE_HIT_CNT_ADDR, 0);
      axil_read(`CACHE_MISS_CNT_ADDR, 0);

      test_name = "backpressure";
      axil_read(12'h244, 4);
      axil_write(12'h010, $random(seed), 4'hf, 1'b1, 4);
      axil_read(`CACHE_MISS_CNT_ADDR, 3);

      test_name = "slverr";
      axil_read(12'h408, 0);
      axil_write(12'h010, $random(seed), 4'h3, 1'b0, 0);  // partial strobe
      axil_write(`CACHE_HIT_CNT_ADDR, $random(seed), 4'hf, 1'b0, 2);  // counters are read-only
      axil_read(12'h010, 0);

      $display(">>> PASS");
      $finish;
   end

endmodule
